// File: verification/uart_stim.hex
// Columns: one hex byte per entry, sent and expected back in order
// @addr starts a test group at a fixed offset
// Line framing, 1 byte
@00
a5
// Loopback order, 10 bytes
@01
00 ff 55 aa 01 80 3c c3 7e 81
// Random output stalls, 12 bytes
@0b
12 34 56 78 9a bc de f0 0f 1e 2d 4b
// CTS hold and transmit FIFO fill, 16 bytes
@17
10 21 32 43 54 65 76 87
98 a9 ba cb dc ed fe 0f
// Receive FIFO full, 16 bytes
@27
e1 d2 c3 b4 a5 96 87 78
69 5a 4b 3c 2d 1e 0f f0

// File: list.f
hdl/uart_line_pkg.sv
hdl/uart_buffer_pkg.sv
hdl/byte_fifo.sv
hdl/uart_tx_serializer.sv
hdl/uart_rx_deserializer.sv
hdl/uart_core.sv
verification/uart_core_tb.sv

// File: run_sim.sh
#!/bin/sh
# Verilator build and run of the UART core testbench
# Exit status follows the verdict found in sim.log

rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal \
    -f list.f --top-module uart_core_tb -o uart_core_sim \
    && ./obj_dir/uart_core_sim > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "Build or simulation did not complete"; exit 1; }

cat sim.log
grep -q "Regression failed" sim.log && exit 1 || exit 0

// File: verification/uart_core_tb.sv
// ==============================
// UART core testbench with serial loopback
// Stimulus from hex file and LFSR output stalls
// Watchdog and per-test report
// ==============================
`timescale 1ns/1ps
`default_nettype none

module uart_core_tb
    import uart_line_pkg::*;
    import uart_buffer_pkg::*;
;

    // ==============================
    // Data file layout and limits
    // ==============================
    localparam int STIM_BYTES  = 55;
    localparam int FRAME_BASE  = 0;
    localparam int LOOP_BASE   = 1;
    localparam int LOOP_BYTES  = 10;
    localparam int STALL_BASE  = 11;
    localparam int STALL_BYTES = 12;
    localparam int CTS_BASE    = 23;
    localparam int FULL_BASE   = 39;

    // Start, data and stop bits of one frame
    localparam int FRAME_BITS  = 1 + DATA_BITS + STOP_BITS;
    localparam int FRAME_CLKS  = FRAME_BITS * CLKS_PER_BIT;
    localparam int PUSH_LIMIT  = (FIFO_DEPTH + 2) * FRAME_CLKS;
    localparam int WATCHDOG_CYCLES = STIM_BYTES * FRAME_CLKS * 4 + 2000;

    logic       i_clk;
    logic       i_arst_n;
    logic [7:0] i_tx_data;
    logic       i_tx_valid;
    wire        o_tx_ready;
    wire  [7:0] o_rx_data;
    wire        o_rx_valid;
    logic       i_rx_ready;
    logic       i_uart_cts_n;
    wire        o_uart_rts_n;
    // Loopback net from txd straight back into rxd
    wire        serial_line;

    logic [7:0]  stim_mem [0:STIM_BYTES-1];
    logic [7:0]  rx_q [$];
    logic [31:0] lfsr_q;
    string       test_name;
    int          test_errors;
    int          total_errors;
    int          tests_passed;
    int          tests_failed;

    uart_core uart_core_i (
        .i_clk        (i_clk),
        .i_arst_n     (i_arst_n),
        .i_tx_data    (i_tx_data),
        .i_tx_valid   (i_tx_valid),
        .o_tx_ready   (o_tx_ready),
        .o_rx_data    (o_rx_data),
        .o_rx_valid   (o_rx_valid),
        .i_rx_ready   (i_rx_ready),
        .o_uart_txd   (serial_line),
        .i_uart_rxd   (serial_line),
        .i_uart_cts_n (i_uart_cts_n),
        .o_uart_rts_n (o_uart_rts_n)
    );

    // 4 ns period
    initial
    begin
        i_clk = 1'b0;
        forever
        begin
            #2 i_clk = ~i_clk;
        end
    end

    // Fibonacci LFSR with taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    // ==============================
    // Handshake tasks
    // ==============================

    // Ready judged at negedge and the transfer lands on the next rising edge
    task automatic push_byte(input logic [7:0] data);
        int waited;
        waited = 0;
        @(posedge i_clk);
        i_tx_valid <= 1'b1;
        i_tx_data  <= data;
        @(negedge i_clk);
        while (!o_tx_ready && waited < PUSH_LIMIT)
        begin
            @(negedge i_clk);
            waited++;
        end
        if (!o_tx_ready)
        begin
            $display("%s: o_tx_ready stayed low, byte %02h never accepted", test_name, data);
            test_errors++;
        end
        @(posedge i_clk);
        i_tx_valid <= 1'b0;
    endtask

    task automatic send_group(input int base, input int n);
        int i;
        for (i = 0; i < n; i++)
        begin
            push_byte(stim_mem[base + i]);
        end
    endtask

    // Pops n bytes into rx_q with ready from the LFSR when stalling
    task automatic collect_bytes(input int n, input bit stall);
        int waited;
        waited = 0;
        while (rx_q.size() < n && waited < (n + 2) * FRAME_CLKS * 2)
        begin
            @(posedge i_clk);
            if (stall)
            begin
                lfsr_q = lfsr_step(lfsr_q);
                i_rx_ready <= lfsr_q[0];
            end
            else
            begin
                i_rx_ready <= 1'b1;
            end
            @(negedge i_clk);
            if (o_rx_valid && i_rx_ready)
            begin
                rx_q.push_back(o_rx_data);
            end
            waited++;
        end
        @(posedge i_clk);
        i_rx_ready <= 1'b0;
        if (rx_q.size() < n)
        begin
            $display("%s: timed out with %0d of %0d bytes received", test_name, rx_q.size(), n);
            test_errors++;
        end
    endtask

    // Received order against the file group
    task automatic compare_received(input int base, input int n);
        int i;
        for (i = 0; i < n && i < rx_q.size(); i++)
        begin
            if (rx_q[i] !== stim_mem[base + i])
            begin
                $display("MISMATCH %s byte %0d: expected %02h, actual %02h",
                         test_name, i, stim_mem[base + i], rx_q[i]);
                test_errors++;
            end
        end
        @(negedge i_clk);
        if (o_rx_valid)
        begin
            $display("%s: extra byte left in the receive FIFO", test_name);
            test_errors++;
        end
        rx_q.delete();
    endtask

    task automatic finish_test();
        if (test_errors == 0)
        begin
            $display("PASS %s", test_name);
            tests_passed++;
        end
        else
        begin
            $display("FAIL %s, %0d errors", test_name, test_errors);
            tests_failed++;
        end
        total_errors += test_errors;
        test_errors = 0;
    endtask

    // ==============================
    // Test sequence
    // ==============================
    initial
    begin
        logic [FRAME_BITS-1:0] frame_bits;
        int waited;
        int accepted;
        int cyc;
        int k;
        logic take;
        logic line_busy;

        i_arst_n     = 1'b0;
        i_tx_data    = '0;
        i_tx_valid   = 1'b0;
        i_rx_ready   = 1'b0;
        i_uart_cts_n = 1'b0;
        lfsr_q       = 32'hf55e77c6;
        test_errors  = 0;
        total_errors = 0;
        tests_passed = 0;
        tests_failed = 0;
        $readmemh("verification/uart_stim.hex", stim_mem);
        repeat (16) @(posedge i_clk);
        i_arst_n <= 1'b1;

        // Outputs right after reset release
        test_name = "reset_state";
        @(negedge i_clk);
        if (serial_line !== 1'b1)
        begin
            $display("MISMATCH %s o_uart_txd: expected 1, actual %0b", test_name, serial_line);
            test_errors++;
        end
        if (o_uart_rts_n !== 1'b1)
        begin
            $display("MISMATCH %s o_uart_rts_n: expected 1, actual %0b", test_name, o_uart_rts_n);
            test_errors++;
        end
        if (o_tx_ready !== 1'b1)
        begin
            $display("MISMATCH %s o_tx_ready: expected 1, actual %0b", test_name, o_tx_ready);
            test_errors++;
        end
        if (o_rx_valid !== 1'b0)
        begin
            $display("MISMATCH %s o_rx_valid: expected 0, actual %0b", test_name, o_rx_valid);
            test_errors++;
        end
        finish_test();

        // Start low, data LSB first, stop high
        test_name  = "line_framing";
        frame_bits = {{STOP_BITS{1'b1}}, stim_mem[FRAME_BASE], 1'b0};
        push_byte(stim_mem[FRAME_BASE]);
        waited = 0;
        @(negedge i_clk);
        while (serial_line !== 1'b0 && waited < FRAME_CLKS)
        begin
            @(negedge i_clk);
            waited++;
        end
        if (serial_line !== 1'b0)
        begin
            $display("%s: no start bit seen on o_uart_txd", test_name);
            test_errors++;
        end
        else
        begin
            // Move to the start-bit centre
            repeat (CLKS_PER_BIT / 2) @(negedge i_clk);
            for (k = 0; k < FRAME_BITS; k++)
            begin
                if (serial_line !== frame_bits[k])
                begin
                    $display("MISMATCH %s bit %0d: expected %0b, actual %0b",
                             test_name, k, frame_bits[k], serial_line);
                    test_errors++;
                end
                repeat (CLKS_PER_BIT) @(negedge i_clk);
            end
        end
        collect_bytes(1, 1'b0);
        compare_received(FRAME_BASE, 1);
        finish_test();

        test_name = "loopback_order";
        fork
            send_group(LOOP_BASE, LOOP_BYTES);
            collect_bytes(LOOP_BYTES, 1'b0);
        join
        compare_received(LOOP_BASE, LOOP_BYTES);
        finish_test();

        test_name = "random_output_stalls";
        fork
            send_group(STALL_BASE, STALL_BYTES);
            collect_bytes(STALL_BYTES, 1'b1);
        join
        compare_received(STALL_BASE, STALL_BYTES);
        finish_test();

        // CTS held off while the transmit FIFO fills to depth
        test_name = "cts_hold_and_fill";
        @(posedge i_clk);
        i_uart_cts_n <= 1'b1;
        repeat (2 * CLKS_PER_BIT) @(posedge i_clk);
        accepted  = 0;
        line_busy = 1'b0;
        i_tx_valid <= 1'b1;
        i_tx_data  <= stim_mem[CTS_BASE];
        for (cyc = 0; cyc < FIFO_DEPTH + 8; cyc++)
        begin
            @(negedge i_clk);
            if (serial_line !== 1'b1)
            begin
                line_busy = 1'b1;
            end
            take = o_tx_ready;
            @(posedge i_clk);
            if (take)
            begin
                accepted++;
                if (accepted < FIFO_DEPTH)
                begin
                    i_tx_data <= stim_mem[CTS_BASE + accepted];
                end
            end
        end
        i_tx_valid <= 1'b0;
        @(negedge i_clk);
        if (accepted != FIFO_DEPTH)
        begin
            $display("MISMATCH %s accepted: expected %0d, actual %0d",
                     test_name, FIFO_DEPTH, accepted);
            test_errors++;
        end
        if (o_tx_ready !== 1'b0)
        begin
            $display("MISMATCH %s o_tx_ready with FIFO full: expected 0, actual %0b",
                     test_name, o_tx_ready);
            test_errors++;
        end
        if (line_busy)
        begin
            $display("%s: o_uart_txd left idle while CTS was deasserted", test_name);
            test_errors++;
        end
        @(posedge i_clk);
        i_uart_cts_n <= 1'b0;
        collect_bytes(FIFO_DEPTH, 1'b0);
        compare_received(CTS_BASE, FIFO_DEPTH);
        finish_test();

        // Output held off until RTS rises
        test_name = "receive_full";
        send_group(FULL_BASE, FIFO_DEPTH);
        waited = 0;
        @(negedge i_clk);
        while (o_uart_rts_n !== 1'b1 && waited < (FIFO_DEPTH + 2) * FRAME_CLKS)
        begin
            @(negedge i_clk);
            waited++;
        end
        if (o_uart_rts_n !== 1'b1)
        begin
            $display("%s: o_uart_rts_n stayed low with the receive FIFO full", test_name);
            test_errors++;
        end
        collect_bytes(FIFO_DEPTH, 1'b0);
        compare_received(FULL_BASE, FIFO_DEPTH);
        repeat (4) @(negedge i_clk);
        if (o_uart_rts_n !== 1'b0)
        begin
            $display("MISMATCH %s o_uart_rts_n after drain: expected 0, actual %0b",
                     test_name, o_uart_rts_n);
            test_errors++;
        end
        finish_test();

        $display("Tests: %0d passed, %0d failed, %0d errors",
                 tests_passed, tests_failed, total_errors);
        if (tests_failed == 0)
        begin
            $display("Regression passed");
        end
        else
        begin
            $display("Regression failed");
        end
        $finish;
    end

    // Four times the line time of every byte in the file
    initial
    begin
        repeat (WATCHDOG_CYCLES) @(posedge i_clk);
        $display("Watchdog expired after %0d cycles, run did not complete", WATCHDOG_CYCLES);
        $display("Regression failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: hdl/uart_core.sv
// ==============================
// UART core top level
// TX FIFO, serializer, deserializer, RX FIFO
// ==============================
`timescale 1ns/1ps
`default_nettype none

module uart_core
    import uart_line_pkg::*;
(
    input  wire        i_clk,
    input  wire        i_arst_n,
    // Transmit byte input
    input  uart_byte_t i_tx_data,
    input  wire        i_tx_valid,
    output logic       o_tx_ready,
    // Receive byte output
    output uart_byte_t o_rx_data,
    output logic       o_rx_valid,
    input  wire        i_rx_ready,
    // Serial line and flow control
    output logic       o_uart_txd,
    input  wire        i_uart_rxd,
    input  wire        i_uart_cts_n,
    output logic       o_uart_rts_n
);

    // Transmit FIFO head to serializer
    uart_byte_t tx_head_data;
    logic       tx_head_valid;
    logic       tx_take;

    // Deserializer to receive FIFO
    uart_byte_t rx_byte_data;
    logic       rx_byte_valid;
    logic       rx_space;

    // ==============================
    // Transmit path
    // ==============================
    byte_fifo u_tx_fifo (
        .i_clk       (i_clk),
        .i_arst_n    (i_arst_n),
        .i_in_data   (i_tx_data),
        .i_in_valid  (i_tx_valid),
        .o_in_ready  (o_tx_ready),
        .o_out_data  (tx_head_data),
        .o_out_valid (tx_head_valid),
        .i_out_ready (tx_take)
    );

    uart_tx_serializer u_tx_serializer (
        .i_clk        (i_clk),
        .i_arst_n     (i_arst_n),
        .i_byte       (tx_head_data),
        .i_byte_valid (tx_head_valid),
        .o_byte_ready (tx_take),
        .i_cts_n      (i_uart_cts_n),
        .o_txd        (o_uart_txd)
    );

    // ==============================
    // Receive path
    // ==============================

    // RTS follows receive FIFO room
    uart_rx_deserializer u_rx_deserializer (
        .i_clk        (i_clk),
        .i_arst_n     (i_arst_n),
        .i_rxd        (i_uart_rxd),
        .i_space      (rx_space),
        .o_byte       (rx_byte_data),
        .o_byte_valid (rx_byte_valid),
        .o_rts_n      (o_uart_rts_n)
    );

    byte_fifo u_rx_fifo (
        .i_clk       (i_clk),
        .i_arst_n    (i_arst_n),
        .i_in_data   (rx_byte_data),
        .i_in_valid  (rx_byte_valid),
        .o_in_ready  (rx_space),
        .o_out_data  (o_rx_data),
        .o_out_valid (o_rx_valid),
        .i_out_ready (i_rx_ready)
    );

endmodule

`default_nettype wire

// File: hdl/uart_rx_deserializer.sv
// ==============================
// Receive deserializer with line filter
// Start detect, mid-bit sampling, RTS control
// ==============================
`timescale 1ns/1ps
`default_nettype none

module uart_rx_deserializer
    import uart_line_pkg::*;
(
    input  wire        i_clk,
    input  wire        i_arst_n,
    // Line side
    input  wire        i_rxd,
    // Room in the receive FIFO
    input  wire        i_space,
    // Assembled byte, valid for one cycle
    output uart_byte_t o_byte,
    output logic       o_byte_valid,
    output logic       o_rts_n
);

    // Newest sample at bit 0
    logic [RXD_FILTER_STAGES-1:0] rxd_hist;

    rx_state_t  state;
    bit_timer_t timer;
    bit_index_t bit_idx;
    uart_byte_t shift_q;

    logic       rx_start;
    logic       bit_end;

    // ==============================
    // Line history and start detect
    // ==============================

    // Idle line is high, so reset to marks
    always_ff @(posedge i_clk or negedge i_arst_n)
    begin
        if (!i_arst_n)
        begin
            rxd_hist <= '1;
        end
        else
        begin
            rxd_hist <= {rxd_hist[RXD_FILTER_STAGES-2:0], i_rxd};
        end
    end

    // Two old highs then two new lows
    // a single-cycle glitch never matches
    assign rx_start = (rxd_hist[RXD_FILTER_STAGES-1 -: 2] == 2'b11)
                   && (rxd_hist[1:0] == 2'b00);

    assign bit_end = timer == bit_timer_t'(CLKS_PER_BIT - 1);

    // Byte shows straight from the shift register
    assign o_byte = shift_q;

    // Data sampled at bit centres, LSB arrives first
    always_ff @(posedge i_clk)
    begin
        if (state == RX_DATA && bit_end)
        begin
            shift_q <= {rxd_hist[0], shift_q[DATA_BITS-1:1]};
        end
    end

    // ==============================
    // Receive state machine
    // ==============================
    always_ff @(posedge i_clk or negedge i_arst_n)
    begin
        if (!i_arst_n)
        begin
            state        <= RX_IDLE;
            timer        <= '0;
            bit_idx      <= '0;
            o_byte_valid <= 1'b0;
            o_rts_n      <= 1'b1;
        end
        else
        begin
            o_byte_valid <= 1'b0;
            case (state)
                // Wait for FIFO room
                // skip the cycle that pushes the last byte
                RX_IDLE:
                begin
                    o_rts_n <= !i_space;
                    timer   <= '0;
                    bit_idx <= '0;
                    if (i_space && !o_byte_valid)
                    begin
                        state <= RX_HUNT;
                    end
                end

                RX_HUNT:
                begin
                    o_rts_n <= 1'b0;
                    if (rx_start)
                    begin
                        timer <= '0;
                        state <= RX_START_MID;
                    end
                end

                // Walk to the start-bit centre
                RX_START_MID:
                begin
                    timer <= timer + bit_timer_t'(1);
                    if (timer == bit_timer_t'(HALF_BIT))
                    begin
                        timer <= '0;
                        state <= RX_DATA;
                    end
                end

                // One full period between samples
                RX_DATA:
                begin
                    timer <= bit_end ? '0 : timer + bit_timer_t'(1);
                    if (bit_end)
                    begin
                        bit_idx <= bit_idx + bit_index_t'(1);
                        if (bit_idx == bit_index_t'(DATA_BITS - 1))
                        begin
                            state <= RX_STOP;
                        end
                    end
                end

                // Byte handed over at the first stop-bit centre
                RX_STOP:
                begin
                    timer <= bit_end ? '0 : timer + bit_timer_t'(1);
                    if (bit_end)
                    begin
                        o_byte_valid <= 1'b1;
                        state        <= RX_IDLE;
                    end
                end

                default:
                begin
                    state <= RX_IDLE;
                end
            endcase
        end
    end

    // FIFO room checked at frame start must still hold at delivery
    a_push_has_room: assert property (
        @(posedge i_clk) disable iff (!i_arst_n)
        $rose(o_byte_valid) |-> i_space
    ) else $error("received byte with receive FIFO full");

endmodule

`default_nettype wire

// File: hdl/uart_tx_serializer.sv
// ==============================
// Transmit serializer with CTS synchronizer
// Bit timer and frame state machine
// ==============================
`timescale 1ns/1ps
`default_nettype none

module uart_tx_serializer
    import uart_line_pkg::*;
(
    input  wire        i_clk,
    input  wire        i_arst_n,
    // Byte from the transmit FIFO
    input  uart_byte_t i_byte,
    input  wire        i_byte_valid,
    output logic       o_byte_ready,
    // Line side
    input  wire        i_cts_n,
    output logic       o_txd
);

    logic [CTS_SYNC_STAGES-1:0] cts_sync;

    tx_state_t  state;
    bit_timer_t timer;
    bit_index_t bit_idx;
    // Outgoing bits, LSB at the bottom
    uart_byte_t shift_q;

    logic       bit_end;

    // ==============================
    // Clear-to-send synchronizer
    // ==============================

    // Resets to deasserted so nothing leaves before CTS is seen
    always_ff @(posedge i_clk or negedge i_arst_n)
    begin
        if (!i_arst_n)
        begin
            cts_sync <= '1;
        end
        else
        begin
            cts_sync <= {cts_sync[CTS_SYNC_STAGES-2:0], i_cts_n};
        end
    end

    // Take only between frames, with all stages showing CTS asserted
    assign o_byte_ready = (state == TX_IDLE) && (cts_sync == '0);

    // Last clock of the current bit period
    assign bit_end = timer == bit_timer_t'(CLKS_PER_BIT - 1);

    // Byte latched at the take edge
    always_ff @(posedge i_clk)
    begin
        if (i_byte_valid && o_byte_ready)
        begin
            shift_q <= i_byte;
        end
        else if (state == TX_DATA && bit_end)
        begin
            shift_q <= shift_q >> 1;
        end
    end

    // ==============================
    // Frame state machine
    // ==============================
    always_ff @(posedge i_clk or negedge i_arst_n)
    begin
        if (!i_arst_n)
        begin
            state   <= TX_IDLE;
            timer   <= '0;
            bit_idx <= '0;
            o_txd   <= 1'b1;
        end
        else
        begin
            case (state)
                TX_IDLE:
                begin
                    o_txd   <= 1'b1;
                    timer   <= '0;
                    bit_idx <= '0;
                    if (i_byte_valid && o_byte_ready)
                    begin
                        state <= TX_START;
                    end
                end

                // Start bit, low for one period
                TX_START:
                begin
                    o_txd <= 1'b0;
                    timer <= bit_end ? '0 : timer + bit_timer_t'(1);
                    if (bit_end)
                    begin
                        state <= TX_DATA;
                    end
                end

                // Data bits, LSB first
                TX_DATA:
                begin
                    o_txd <= shift_q[0];
                    timer <= bit_end ? '0 : timer + bit_timer_t'(1);
                    if (bit_end)
                    begin
                        bit_idx <= bit_idx + bit_index_t'(1);
                        if (bit_idx == bit_index_t'(DATA_BITS - 1))
                        begin
                            bit_idx <= '0;
                            state   <= TX_STOP;
                        end
                    end
                end

                // Stop time, bit_idx counts whole periods
                TX_STOP:
                begin
                    o_txd <= 1'b1;
                    timer <= bit_end ? '0 : timer + bit_timer_t'(1);
                    if (bit_end)
                    begin
                        bit_idx <= bit_idx + bit_index_t'(1);
                        if (bit_idx == bit_index_t'(STOP_BITS - 1))
                        begin
                            state <= TX_IDLE;
                        end
                    end
                end

                default:
                begin
                    o_txd <= 1'b1;
                    state <= TX_IDLE;
                end
            endcase
        end
    end

    // Line must rest high whenever no frame is active
    a_idle_mark: assert property (
        @(posedge i_clk) disable iff (!i_arst_n)
        state == TX_IDLE |-> o_txd
    ) else $error("txd low while serializer idle");

endmodule

`default_nettype wire

// File: hdl/byte_fifo.sv
// ==============================
// Show-ahead byte FIFO, valid/ready on both sides
// Occupancy and output stability assertions
// ==============================
`timescale 1ns/1ps
`default_nettype none

module byte_fifo
    import uart_line_pkg::*;
    import uart_buffer_pkg::*;
(
    input  wire        i_clk,
    input  wire        i_arst_n,
    // Write side
    input  uart_byte_t i_in_data,
    input  wire        i_in_valid,
    output logic       o_in_ready,
    // Read side, head entry shown ahead
    output uart_byte_t o_out_data,
    output logic       o_out_valid,
    input  wire        i_out_ready
);

    // Storage, no reset on payload
    uart_byte_t  mem [FIFO_DEPTH];

    fifo_ptr_t   wr_ptr;
    fifo_ptr_t   rd_ptr;
    fifo_count_t count;

    logic        wr_en;
    logic        rd_en;

    // ==============================
    // Flags from occupancy only
    // ==============================
    assign o_in_ready  = count < fifo_count_t'(FIFO_DEPTH);
    assign o_out_valid = count != '0;

    // Oldest entry, same cycle
    assign o_out_data  = mem[rd_ptr];

    assign wr_en = i_in_valid && o_in_ready;
    assign rd_en = o_out_valid && i_out_ready;

    always_ff @(posedge i_clk)
    begin
        if (wr_en)
        begin
            mem[wr_ptr] <= i_in_data;
        end
    end

    // Pointers and count
    always_ff @(posedge i_clk or negedge i_arst_n)
    begin
        if (!i_arst_n)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (wr_en)
            begin
                wr_ptr <= wr_ptr + fifo_ptr_t'(1);
            end
            if (rd_en)
            begin
                rd_ptr <= rd_ptr + fifo_ptr_t'(1);
            end
            // Push and pop together keep the count
            case ({wr_en, rd_en})
                2'b10:   count <= count + fifo_count_t'(1);
                2'b01:   count <= count - fifo_count_t'(1);
                default: count <= count;
            endcase
        end
    end

    // ==============================
    // Assertions
    // ==============================

    // Never more entries than storage
    a_count_bound: assert property (
        @(posedge i_clk) disable iff (!i_arst_n)
        count <= fifo_count_t'(FIFO_DEPTH)
    ) else $error("byte_fifo count above depth");

    // Held head must not change under a stall, even with a push behind it
    a_head_stable: assert property (
        @(posedge i_clk) disable iff (!i_arst_n)
        o_out_valid && !i_out_ready |=> $stable(o_out_data)
    ) else $error("byte_fifo head changed while stalled");

endmodule

`default_nettype wire

// File: hdl/uart_buffer_pkg.sv
// ==============================
// FIFO depth constants
// Pointer and occupancy types
// ==============================
`default_nettype none

package uart_buffer_pkg;

    // Entries per FIFO, same for transmit and receive
    localparam int FIFO_DEPTH = 16;
    // Pointer width, wraps naturally at FIFO_DEPTH
    localparam int FIFO_PTR_W = 4;

    // Read and write pointers
    typedef logic [FIFO_PTR_W-1:0] fifo_ptr_t;

    // Occupancy, one extra bit to hold a full count
    typedef logic [FIFO_PTR_W:0] fifo_count_t;

endpackage

`default_nettype wire

// File: hdl/uart_line_pkg.sv
// ==============================
// Line format constants, byte and counter types
// Serializer and deserializer state encodings
// ==============================
`default_nettype none

package uart_line_pkg;

    // ==============================
    // Line timing
    // ==============================

    // Clocks per bit period, kept small for simulation
    localparam int CLKS_PER_BIT = 12;
    // Start edge to start-bit centre, filter delay taken off
    localparam int HALF_BIT = 2;

    // ==============================
    // Frame format
    // ==============================

    localparam int DATA_BITS = 8;
    // Stop time in whole bit periods
    localparam int STOP_BITS = 2;

    // Input conditioning depths
    localparam int CTS_SYNC_STAGES = 3;
    localparam int RXD_FILTER_STAGES = 5;

    // Data byte on the line and in the FIFOs
    typedef logic [DATA_BITS-1:0] uart_byte_t;
    // Clock count inside one bit period
    typedef logic [$clog2(CLKS_PER_BIT)-1:0] bit_timer_t;
    // Data bit position, also reused for stop periods
    typedef logic [2:0] bit_index_t;

    typedef enum logic [1:0]
    {
        TX_IDLE,
        TX_START,
        TX_DATA,
        TX_STOP
    } tx_state_t;

    typedef enum logic [2:0]
    {
        RX_IDLE,
        RX_HUNT,
        RX_START_MID,
        RX_DATA,
        RX_STOP
    } rx_state_t;

endpackage

`default_nettype wire
